//--- vlog.f
+incdir+.
fetch_pkg.sv
cacheline_adapter.sv
fetch_ctrl.sv
inst_queue.sv
fetch_top.sv
tb_fetch_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_fetch_top
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= SIMULATION FAILED
PASS_MSG  ?= SIMULATION PASSED

SOURCES := $(wildcard *.sv *.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test run failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "test run ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_fetch_top.sv
`timescale 1ns/1ps
`include "fetch_settings.svh"

module tb_fetch_top;
    import fetch_pkg::*;

    localparam addr_t LINE_MASK  = ~addr_t'((1 << (`WORD_SEL_BITS + 2)) - 1);
    localparam addr_t LINE_BYTES = addr_t'(8 * `BEATS_PER_LINE);
    localparam addr_t INST_KEY   = 32'hC0DE0000;    // inst word = address ^ key
    // cycle budget: reset, stream, credits, redirect, stalls
    localparam int EXPECTED_CYCLES = 15 + 100 + 110 + 60 + 220;
    localparam int TIMEOUT_CYCLES  = 4 * EXPECTED_CYCLES;

    logic         clk;
    logic         rst;
    addr_t        bmem_addr_o;
    logic         bmem_read_o;
    logic         bmem_ready_i;
    beat_t        bmem_rdata_i;
    logic         bmem_rvalid_i;
    logic         redirect_i;
    addr_t        redirect_pc_i;
    logic         credit_return_i;
    logic         out_valid_o;
    fetch_entry_t out_entry_o;

    logic [15:0]  lfsr = 16'd34225;
    int           cycle_cnt = 0;
    logic         stall_mode = 1'b0;    // low ready and long beat gaps
    logic         withhold = 1'b0;      // decode keeps its credits
    logic         mem_busy = 1'b0;
    addr_t        mem_line;
    addr_t        exp_req = addr_t'(`RESET_PC) & LINE_MASK;    // next line memory should see
    int           beat_idx = 0;
    int           gap_cnt = 0;
    int           held = 0;             // entries not yet given back
    addr_t        exp_pc = `RESET_PC;
    int           n_recv = 0;
    logic         redirect_last = 1'b0;
    fetch_entry_t last_entry;

    fetch_top fetch_top_i (
        .clk             (clk),
        .rst             (rst),
        .bmem_addr_o     (bmem_addr_o),
        .bmem_read_o     (bmem_read_o),
        .bmem_ready_i    (bmem_ready_i),
        .bmem_rdata_i    (bmem_rdata_i),
        .bmem_rvalid_i   (bmem_rvalid_i),
        .redirect_i      (redirect_i),
        .redirect_pc_i   (redirect_pc_i),
        .credit_return_i (credit_return_i),
        .out_valid_o     (out_valid_o),
        .out_entry_o     (out_entry_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);   // galois taps 16,14,13,11
    endfunction

    task automatic take_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
    endtask

    function automatic inst_t inst_of(input addr_t a);
        inst_of = a ^ INST_KEY;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_inst(input string name, input inst_t got, input inst_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_entry(input string name, input fetch_entry_t got,
                               input fetch_entry_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic drive_memory();
        int r;
        bmem_rvalid_i = 1'b0;
        bmem_ready_i  = 1'b0;
        if (rst) begin
            return;
        end
        if (mem_busy) begin
            if (gap_cnt != 0) begin
                gap_cnt--;
            end else begin
                bmem_rvalid_i = 1'b1;
                bmem_rdata_i  = {inst_of(mem_line + addr_t'(8 * beat_idx + 4)),
                                 inst_of(mem_line + addr_t'(8 * beat_idx))};
            end
        end else begin
            take_bits(2, r);
            bmem_ready_i = stall_mode ? (r == 0) : (r != 0);
        end
    endtask

    task automatic observe_memory();
        int r;
        if (mem_busy && bmem_rvalid_i) begin
            beat_idx++;
            if (beat_idx == `BEATS_PER_LINE) begin
                mem_busy = 1'b0;
            end else begin
                take_bits(stall_mode ? 4 : 1, r);   // gap before the next beat
                gap_cnt = r;
            end
        end
        if (bmem_read_o && bmem_ready_i) begin  // taken at the coming edge
            check_addr("bmem_addr_o", bmem_addr_o, exp_req);
            mem_line = bmem_addr_o;
            mem_busy = 1'b1;
            beat_idx = 0;
            exp_req  = exp_req + LINE_BYTES;    // lines are fetched in order
            take_bits(stall_mode ? 4 : 1, r);
            gap_cnt = r;
        end
        if (redirect_i) begin
            exp_req = redirect_pc_i & LINE_MASK;    // fetch restarts at the target line
        end
    endtask

    task automatic drive_decode();
        int r;
        credit_return_i = 1'b0;
        if (!rst && !withhold && held > 0) begin
            take_bits(1, r);
            if (r != 0) begin
                credit_return_i = 1'b1;
                held--;
            end
        end
    endtask

    task automatic observe_decode();
        fetch_entry_t exp_e;
        if (redirect_last && out_valid_o) begin
            fail_run("an entry was delivered in the cycle after a redirect");
        end
        if (out_valid_o) begin
            held++;
            if (held > `FETCH_CREDITS) begin
                fail_run("decode holds more entries than it has credits");
            end
            exp_e.pc   = exp_pc;
            exp_e.inst = inst_of(exp_pc);
            check_entry("out_entry_o", out_entry_o, exp_e);
            last_entry = out_entry_o;
            exp_pc     = exp_pc + 32'd4;
            n_recv++;
        end
        redirect_last = redirect_i;
        if (redirect_i) begin
            exp_pc = redirect_pc_i;             // older entries are gone after this
        end
    endtask

    // memory and decode models, driven after the edge and sampled mid cycle
    initial begin
        forever begin
            @(posedge clk);
            #2;
            drive_memory();
            drive_decode();
            @(negedge clk);
            observe_memory();
            observe_decode();
        end
    end

    initial begin
        forever begin
            @(posedge clk);
            cycle_cnt++;
            if (cycle_cnt >= TIMEOUT_CYCLES) begin
                fail_run($sformatf("timeout: run exceeded %0d cycles", TIMEOUT_CYCLES));
            end
        end
    end

    task automatic wait_entries(input int n);
        while (n_recv < n) begin
            @(posedge clk);
        end
    endtask

    task automatic do_redirect(input addr_t target);
        @(posedge clk);
        #2;
        redirect_i    = 1'b1;
        redirect_pc_i = target;
        @(posedge clk);
        #2;
        redirect_i = 1'b0;
    endtask

    task automatic reset_checks();
        repeat (10) begin
            @(negedge clk);
            if (out_valid_o !== 1'b0 || bmem_read_o !== 1'b0) begin
                fail_run("out_valid_o or bmem_read_o is not low during reset");
            end
        end
        @(posedge clk);
        #2;
        rst = 1'b0;
        @(posedge clk);
        @(negedge clk);
        if (bmem_read_o !== 1'b1 || out_valid_o !== 1'b0) begin
            fail_run("no line request in the first cycle after reset");
        end
        check_addr("bmem_addr_o", bmem_addr_o, addr_t'(`RESET_PC) & LINE_MASK);
    endtask

    task automatic sequential_stream();
        wait_entries(40);                       // order checked per entry
    endtask

    task automatic credit_backpressure();
        int n0;
        withhold = 1'b1;
        repeat (60) @(posedge clk);
        if (held != `FETCH_CREDITS) begin
            fail_run("decode did not reach its full credit count while withholding");
        end
        withhold = 1'b0;
        n0 = n_recv;
        wait_entries(n0 + 24);
    endtask

    task automatic redirect_mid_line();
        int    n0;
        addr_t target;
        target = 32'h2000_0A14;                 // word 5 of its line
        do begin
            @(posedge clk);
        end while (!mem_busy);
        do_redirect(target);
        n0 = n_recv;
        wait_entries(n0 + 1);
        check_addr("out_entry_o.pc", last_entry.pc, target);
        check_inst("out_entry_o.inst", last_entry.inst, inst_of(target));
        wait_entries(n0 + 20);
    endtask

    task automatic memory_stalls();
        int n0;
        stall_mode = 1'b1;
        do_redirect(`RESET_PC);                 // replay the stream from reset pc
        n0 = n_recv;
        wait_entries(n0 + 40);
        stall_mode = 1'b0;
    endtask

    initial begin
        rst             = 1'b1;
        bmem_ready_i    = 1'b0;
        bmem_rdata_i    = '0;
        bmem_rvalid_i   = 1'b0;
        redirect_i      = 1'b0;
        redirect_pc_i   = '0;
        credit_return_i = 1'b0;
        reset_checks();
        sequential_stream();
        credit_backpressure();
        redirect_mid_line();
        memory_stalls();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
    input  logic                    clk,
    input  logic                    rst,
    output fetch_pkg::addr_t        bmem_addr_o,
    output logic                    bmem_read_o,
    input  logic                    bmem_ready_i,
    input  fetch_pkg::beat_t        bmem_rdata_i,
    input  logic                    bmem_rvalid_i,
    input  logic                    redirect_i,
    input  fetch_pkg::addr_t        redirect_pc_i,
    input  logic                    credit_return_i,
    output logic                    out_valid_o,
    output fetch_pkg::fetch_entry_t out_entry_o
);
    import fetch_pkg::*;

    line_t        line;
    logic         line_valid;
    logic         iq_full;
    logic         push;
    fetch_entry_t push_entry;

    cacheline_adapter cacheline_adapter_i (
        .clk           (clk),
        .rst           (rst),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i),
        .line_o        (line),
        .line_valid_o  (line_valid)
    );

    fetch_ctrl fetch_ctrl_i (
        .clk           (clk),
        .rst           (rst),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .bmem_ready_i  (bmem_ready_i),
        .bmem_addr_o   (bmem_addr_o),
        .bmem_read_o   (bmem_read_o),
        .line_i        (line),
        .line_valid_i  (line_valid),
        .iq_full_i     (iq_full),
        .push_o        (push),
        .push_entry_o  (push_entry)
    );

    inst_queue inst_queue_i (
        .clk             (clk),
        .rst             (rst),
        .flush_i         (redirect_i),     // redirect empties the queue
        .push_i          (push),
        .push_entry_i    (push_entry),
        .full_o          (iq_full),
        .credit_return_i (credit_return_i),
        .out_valid_o     (out_valid_o),
        .out_entry_o     (out_entry_o)
    );

endmodule

//--- inst_queue.sv
`timescale 1ns/1ps
`include "fetch_settings.svh"

module inst_queue (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush_i,
    input  logic                    push_i,
    input  fetch_pkg::fetch_entry_t push_entry_i,
    output logic                    full_o,
    input  logic                    credit_return_i,
    output logic                    out_valid_o,
    output fetch_pkg::fetch_entry_t out_entry_o
);
    import fetch_pkg::*;

    localparam int PTR_BITS  = $clog2(`IQ_DEPTH);
    localparam int CRED_BITS = $clog2(`FETCH_CREDITS + 1);

    fetch_entry_t         entries [`IQ_DEPTH];
    logic [PTR_BITS-1:0]  head;
    logic [PTR_BITS-1:0]  tail;
    logic [PTR_BITS:0]    count;
    logic [CRED_BITS-1:0] credits;     // decode buffer slots still free
    logic                 empty;
    logic                 enq;
    logic                 deliver;

    assign full_o  = (count == (PTR_BITS + 1)'(`IQ_DEPTH));
    assign empty   = (count == '0);
    assign enq     = push_i && !flush_i;    // flush drops a same-cycle push
    assign deliver = !flush_i && !empty && (credits != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            head        <= '0;
            tail        <= '0;
            count       <= '0;
            credits     <= CRED_BITS'(`FETCH_CREDITS);
            out_valid_o <= 1'b0;
        end else begin
            out_valid_o <= deliver;
            if (flush_i) begin
                head  <= '0;
                tail  <= '0;
                count <= '0;
            end else begin
                if (enq) begin
                    tail <= tail + 1'b1;
                end
                if (deliver) begin
                    head <= head + 1'b1;
                end
                case ({enq, deliver})
                    2'b10:   count <= count + 1'b1;
                    2'b01:   count <= count - 1'b1;
                    default: count <= count;
                endcase
            end
            case ({deliver, credit_return_i})   // credits survive a flush
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (enq) begin
            entries[tail] <= push_entry_i;
        end
        if (deliver) begin
            out_entry_o <= entries[head];
        end
    end

    // decode never hands back more than it was given
    a_credit_max : assert property (
        @(posedge clk) disable iff (rst) credits <= CRED_BITS'(`FETCH_CREDITS)
    );

    // fetch_ctrl must respect full
    a_no_push_full : assert property (
        @(posedge clk) disable iff (rst) full_o |-> !push_i
    );

endmodule

//--- fetch_ctrl.sv
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetch_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    redirect_i,
    input  fetch_pkg::addr_t        redirect_pc_i,
    input  logic                    bmem_ready_i,
    output fetch_pkg::addr_t        bmem_addr_o,
    output logic                    bmem_read_o,
    input  fetch_pkg::line_t        line_i,
    input  logic                    line_valid_i,
    input  logic                    iq_full_i,
    output logic                    push_o,
    output fetch_pkg::fetch_entry_t push_entry_o
);
    import fetch_pkg::*;

    localparam int OFS_BITS = `WORD_SEL_BITS + 2;   // byte offset within a line

    fetch_state_t state;
    fetch_state_t state_next;
    addr_t        pc;
    addr_t        pc_next;
    word_sel_t    wsel;
    logic         read_q;
    logic         accepted;
    logic         burst_open;

    assign wsel        = pc[2 +: `WORD_SEL_BITS];
    assign accepted    = read_q && bmem_ready_i;
    assign bmem_read_o = read_q;
    assign bmem_addr_o = {pc[31:OFS_BITS], OFS_BITS'(0)};     // line aligned

    // memory still owes beats after this cycle
    assign burst_open = ((state == REQ) && accepted) ||
                        (((state == WAIT) || (state == DISCARD)) && !line_valid_i);

    // line stays put in the adapter until the next burst
    assign push_o            = (state == PUSH) && !iq_full_i;
    assign push_entry_o.pc   = pc;
    assign push_entry_o.inst = line_i[wsel*$bits(inst_t) +: $bits(inst_t)];

    always_comb begin
        state_next = state;
        pc_next    = pc;
        case (state)
            REQ: begin
                if (accepted) begin
                    state_next = WAIT;
                end
            end
            WAIT: begin
                if (line_valid_i) begin
                    state_next = PUSH;
                end
            end
            PUSH: begin
                if (push_o) begin
                    pc_next = pc + 32'd4;       // word 7 rolls into the next line
                    if (wsel == '1) begin
                        state_next = REQ;
                    end
                end
            end
            DISCARD: begin
                if (line_valid_i) begin
                    state_next = REQ;           // stale line dropped
                end
            end
            default: state_next = REQ;
        endcase
        if (redirect_i) begin
            pc_next    = redirect_pc_i;
            state_next = burst_open ? DISCARD : REQ;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= REQ;
            pc     <= `RESET_PC;
            read_q <= 1'b0;
        end else begin
            state  <= state_next;
            pc     <= pc_next;
            read_q <= (state_next == REQ);
        end
    end

    // pending request holds its address until memory takes it
    a_addr_stable : assert property (
        @(posedge clk) disable iff (rst)
        bmem_read_o && !bmem_ready_i && !redirect_i |=> bmem_read_o && $stable(bmem_addr_o)
    );

endmodule

//--- cacheline_adapter.sv
`timescale 1ns/1ps
`include "fetch_settings.svh"

module cacheline_adapter (
    input  logic             clk,
    input  logic             rst,
    input  fetch_pkg::beat_t bmem_rdata_i,
    input  logic             bmem_rvalid_i,
    output fetch_pkg::line_t line_o,
    output logic             line_valid_o
);
    import fetch_pkg::*;

    localparam int CNT_BITS = $clog2(`BEATS_PER_LINE);

    logic [CNT_BITS-1:0] beat_cnt;      // beats taken so far
    line_t               line_q;
    logic                last_beat;

    assign last_beat = bmem_rvalid_i && (beat_cnt == CNT_BITS'(`BEATS_PER_LINE - 1));
    assign line_o    = line_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt     <= '0;
            line_valid_o <= 1'b0;
        end else begin
            line_valid_o <= last_beat;      // one cycle after the final beat
            if (bmem_rvalid_i) begin
                if (last_beat) begin
                    beat_cnt <= '0;
                end else begin
                    beat_cnt <= beat_cnt + 1'b1;
                end
            end
        end
    end

    // beats arrive in address order so each new one enters at the top
    // and the first beat ends up in the lowest 64 bits
    always_ff @(posedge clk) begin
        if (bmem_rvalid_i) begin
            line_q <= {bmem_rdata_i, line_q[$bits(line_t)-1:$bits(beat_t)]};
        end
    end

    // bursts never overlap, so a completed line is a single pulse
    a_line_pulse : assert property (
        @(posedge clk) disable iff (rst) line_valid_o |=> !line_valid_o
    );

endmodule

//--- fetch_pkg.sv
`include "fetch_settings.svh"

package fetch_pkg;

    typedef logic [31:0]  addr_t;   // byte address
    typedef logic [31:0]  inst_t;   // one instruction word
    typedef logic [63:0]  beat_t;   // one memory beat
    typedef logic [255:0] line_t;   // word k at bit 32k, beat k at bit 64k

    typedef logic [`WORD_SEL_BITS-1:0] word_sel_t;  // word slot in a line

    // pc and instruction pair handed to decode
    typedef struct packed {
        addr_t pc;
        inst_t inst;
    } fetch_entry_t;

    // line request machine in fetch_ctrl
    typedef enum logic [1:0] {
        REQ,        // read raised towards memory
        WAIT,       // burst accepted, line pending
        PUSH,       // walking words into the queue
        DISCARD     // burst made stale by a redirect
    } fetch_state_t;

endpackage

//--- fetch_settings.svh
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// pc loaded on reset
`define RESET_PC 32'h1ECEB000

// instruction queue entries
`define IQ_DEPTH 8

// credits held by decode after reset
`define FETCH_CREDITS 4

// 64-bit beats per 256-bit line
`define BEATS_PER_LINE 4

// word index within a line
`define WORD_SEL_BITS 3

`endif
